/* common/plotter_pkg.sv */
package plotter_pkg;

    // *********************************************************************
    // widths and sizing
    // *********************************************************************
    localparam int coord_w          = 12;
    localparam int color_w          = 8;
    localparam int word_w           = 16;
    localparam int coord_regs       = 4;             // x0..x3 / y0..y3
    localparam int fifo_depth       = 16;
    localparam int fifo_almost_full = fifo_depth - 2;
    localparam int fifo_ptr_w       = $clog2(fifo_depth);

    typedef logic [coord_w-1:0] coord_t;             // screen coordinate
    typedef logic [color_w-1:0] color_t;             // pen color / mode byte
    typedef logic [word_w-1:0]  cmd_word_t;          // fifo word: opcode byte + data byte
    typedef logic [7:0]         opcode_t;
    typedef logic [35:0]        draw_cmd_t;          // func | color | y | x

    // output function codes towards the pixel writer
    typedef enum logic [3:0] {
        fn_nop           = 4'd0,
        fn_pxwri         = 4'd1,
        fn_rst_pxwri_m   = 4'd10,
        fn_rst_pxpaste_m = 4'd11,
        fn_dstrwdth      = 4'd12,
        fn_srcrwdth      = 4'd13,
        fn_dstmaddr      = 4'd14,
        fn_srcmaddr      = 4'd15
    } draw_func_t;

    // *********************************************************************
    // command byte opcodes
    // *********************************************************************
    localparam logic [1:0] op_load_x   = 2'b10;      // 10aa_dddd, aa picks the pair
    localparam logic [1:0] op_load_y   = 2'b11;
    localparam opcode_t    op_dstmaddr = 8'h7c;      // 0x7c..0x7f
    localparam opcode_t    op_srcmaddr = 8'h78;      // 0x78..0x7b
    localparam opcode_t    op_rwdth    = 8'd112;     // 112..115
    localparam opcode_t    op_limit    = 8'd92;      // 92..95
    localparam opcode_t    op_mask_rst = 8'd90;      // 90, 91
    localparam logic [2:0] op_draw     = 3'b000;     // 000f_fsss
    localparam logic [2:0] shape_line  = 3'd1;
    localparam logic [2:0] shape_rect  = 3'd2;

    function automatic draw_cmd_t make_draw_cmd(draw_func_t func, color_t color,
                                                coord_t y, coord_t x);
        return {func, color, y, x};
    endfunction

    // -1, 0 or +1 as a 12 bit step
    function automatic coord_t step_dir(coord_t from, coord_t to);
        if (to < from) return '1;
        if (to == from) return '0;
        return coord_t'(1);
    endfunction

    function automatic coord_t abs_span(coord_t a, coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

endpackage

/* src/cmd_fifo.sv */
`timescale 1ns/1ns

module cmd_fifo import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wr,                            // write strobe from the host port
    input  cmd_word_t wr_data,
    input  logic      pop,
    output cmd_word_t head_word,                     // show-ahead head of queue
    output logic      head_valid,
    output logic      almost_full
);

    cmd_word_t             mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;                    // one extra bit to hold fifo_depth
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr       = wr && (count != (fifo_ptr_w+1)'(fifo_depth)); // full -> word lost
    assign do_rd       = pop && head_valid;                              // empty pop ignored
    assign head_valid  = (count != '0);
    assign head_word   = mem[rd_ptr];                                    // no read latency
    assign almost_full = (count >= (fifo_ptr_w+1)'(fifo_almost_full));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;             // depth is a power of two, wraps
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

/* src/cmd_decoder.sv */
`timescale 1ns/1ns

module cmd_decoder import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  cmd_word_t head_word,
    input  logic      head_valid,
    input  logic      draw_busy,
    input  logic      engine_running,
    output logic      pop,
    output logic      cfg_req,                       // one cycle per config command
    output draw_cmd_t cfg_cmd,
    output coord_t    max_x,                         // screen limit for clipping
    output coord_t    max_y,
    output logic      line_start,
    output logic      rect_start,
    output coord_t    x0,
    output coord_t    y0,
    output coord_t    x1,
    output coord_t    y1,
    output logic      fill,
    output color_t    pen_color
);

    coord_t     x_reg [coord_regs];
    coord_t     y_reg [coord_regs];
    opcode_t    opcode;
    color_t     data8;
    coord_t     data12;
    logic [1:0] addr_sel;                            // pair for address commands
    logic [1:0] wid_sel;                             // pair for raster width commands
    logic [1:0] lim_sel;                             // 95 -> pair 0 ... 92 -> pair 3
    logic       cfg_hit;
    draw_cmd_t  cfg_next;
    logic       is_draw;

    assign opcode   = head_word[15:8];
    assign data8    = head_word[7:0];
    assign data12   = head_word[coord_w-1:0];
    assign addr_sel = opcode[1:0];
    assign wid_sel  = (opcode == op_rwdth) ? 2'd3 : 2'd2;
    assign lim_sel  = ~opcode[1:0];
    assign is_draw  = (opcode[7:5] == op_draw);

    // hold off while a start strobe is still on its way to an engine
    assign pop = head_valid && !engine_running && !draw_busy && !line_start && !rect_start;

    assign x0 = x_reg[0];
    assign y0 = y_reg[0];
    assign x1 = x_reg[1];
    assign y1 = y_reg[1];

    // *********************************************************************
    // configuration command decode
    // *********************************************************************
    always_comb begin
        cfg_hit  = 1'b1;
        cfg_next = '0;
        if (opcode[7:2] == op_dstmaddr[7:2]) begin
            cfg_next = make_draw_cmd(fn_dstmaddr, data8, y_reg[addr_sel], x_reg[addr_sel]);
        end else if (opcode[7:2] == op_srcmaddr[7:2]) begin
            cfg_next = make_draw_cmd(fn_srcmaddr, data8, y_reg[addr_sel], x_reg[addr_sel]);
        end else if (opcode[7:2] == op_rwdth[7:2]) begin
            if (opcode[0])                           // 113, 115 dest
                cfg_next = make_draw_cmd(fn_dstrwdth, data8, y_reg[wid_sel], x_reg[wid_sel]);
            else                                     // 112, 114 source
                cfg_next = make_draw_cmd(fn_srcrwdth, data8, y_reg[wid_sel], x_reg[wid_sel]);
        end else if (opcode[7:1] == op_mask_rst[7:1]) begin
            // mask colors spread over y and x
            if (opcode[0])
                cfg_next = make_draw_cmd(fn_rst_pxwri_m, data8, {data8, data8[7:4]},
                                         {4'h0, data8[3:0], data8[7:4]});
            else
                cfg_next = make_draw_cmd(fn_rst_pxpaste_m, data8, {data8, data8[7:4]},
                                         {4'h0, data8[3:0], data8[7:4]});
        end else begin
            cfg_hit = 1'b0;                          // loads, limits, draws, no-ops
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < coord_regs; i++) begin
                x_reg[i] <= '0;
                y_reg[i] <= '0;
            end
            max_x      <= '0;
            max_y      <= '0;
            cfg_req    <= 1'b0;
            line_start <= 1'b0;
            rect_start <= 1'b0;
        end else begin
            cfg_req    <= pop && cfg_hit;
            line_start <= pop && is_draw && (opcode[2:0] == shape_line);
            rect_start <= pop && is_draw && (opcode[2:0] == shape_rect);
            if (pop) begin
                if (opcode[7:6] == op_load_x)
                    x_reg[opcode[5:4]] <= data12;
                else if (opcode[7:6] == op_load_y)
                    y_reg[opcode[5:4]] <= data12;
                else if (opcode[7:2] == op_limit[7:2]) begin
                    max_x <= x_reg[lim_sel];
                    max_y <= y_reg[lim_sel];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cfg_cmd   <= cfg_next;
            fill      <= opcode[3];                  // only meaningful for draw words
            pen_color <= data8;
        end
    end

endmodule

/* geometry/line_engine.sv */
`timescale 1ns/1ns

module line_engine import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      draw_busy,
    input  coord_t    x0,
    input  coord_t    y0,
    input  coord_t    x1,
    input  coord_t    y1,
    input  color_t    pen_color,
    output logic      running,
    output logic      pix_req,
    output draw_cmd_t pix_cmd
);

    typedef enum logic [1:0] {
        l_idle,
        l_setup,                                     // load the error term
        l_plot,
        l_finish                                     // last pixel out, drop running
    } line_state_t;

    line_state_t        state;
    coord_t             cur_x;
    coord_t             cur_y;
    coord_t             end_x;
    coord_t             end_y;
    coord_t             dir_x;
    coord_t             dir_y;
    color_t             color;
    logic signed [13:0] dx;                          // +|x1-x0|
    logic signed [13:0] dy;                          // -|y1-y0|
    logic signed [13:0] err;
    logic signed [14:0] e2;
    logic               at_end;

    assign running = (state != l_idle);
    assign e2      = {err, 1'b0};
    assign at_end  = (cur_x == end_x) && (cur_y == end_y);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= l_idle;
            pix_req <= 1'b0;
        end else begin
            pix_req <= 1'b0;
            case (state)
                l_idle:   if (start) state <= l_setup;
                l_setup:  if (!draw_busy) state <= l_plot;
                l_plot: begin
                    if (!draw_busy) begin
                        pix_req <= 1'b1;
                        if (at_end)
                            state <= l_finish;
                    end
                end
                l_finish: state <= l_idle;
            endcase
        end
    end

    // *********************************************************************
    // point and error term
    // *********************************************************************
    always_ff @(posedge clk) begin
        if (state == l_idle && start) begin
            cur_x <= x0;
            cur_y <= y0;
            end_x <= x1;
            end_y <= y1;
            dir_x <= step_dir(x0, x1);
            dir_y <= step_dir(y0, y1);
            dx    <= $signed({2'b00, abs_span(x0, x1)});
            dy    <= -$signed({2'b00, abs_span(y0, y1)});
            color <= pen_color;
        end else if (state == l_setup && !draw_busy) begin
            err <= dx + dy;
        end else if (state == l_plot && !draw_busy) begin
            pix_cmd <= make_draw_cmd(fn_pxwri, color, cur_y, cur_x);
            if (e2 > dy) begin
                cur_x <= cur_x + dir_x;
                if (e2 + dy < dx) begin              // diagonal step
                    cur_y <= cur_y + dir_y;
                    err   <= err + dx + dy;
                end else begin
                    err <= err + dy;
                end
            end else if (e2 < dx) begin
                cur_y <= cur_y + dir_y;
                err   <= err + dx;
            end
        end
    end

endmodule

/* geometry/rect_engine.sv */
`timescale 1ns/1ns

module rect_engine import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      draw_busy,
    input  coord_t    x0,
    input  coord_t    y0,
    input  coord_t    x1,
    input  coord_t    y1,
    input  logic      fill,
    input  color_t    pen_color,
    output logic      running,
    output logic      pix_req,
    output draw_cmd_t pix_cmd
);

    typedef enum logic [1:0] {
        r_idle,
        r_scan,                                      // one pixel per cycle along the row
        r_next_row                                   // no pixel, rewind x and step y
    } rect_state_t;

    rect_state_t state;
    coord_t      cur_x;
    coord_t      cur_y;
    coord_t      start_x;
    coord_t      start_y;
    coord_t      end_x;
    coord_t      end_y;
    coord_t      dir_x;
    coord_t      dir_y;
    color_t      color;
    logic        fill_r;
    logic        solid_row;                          // whole row gets drawn

    assign running   = (state != r_idle);
    assign solid_row = fill_r || (cur_y == start_y) || (cur_y == end_y);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= r_idle;
            pix_req <= 1'b0;
        end else begin
            pix_req <= 1'b0;
            case (state)
                r_idle: if (start) state <= r_scan;
                r_scan: begin
                    if (!draw_busy) begin
                        pix_req <= 1'b1;
                        if (cur_x == end_x)
                            state <= r_next_row;
                    end
                end
                r_next_row: if (!draw_busy) state <= (cur_y == end_y) ? r_idle : r_scan;
                default:    state <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == r_idle && start) begin
            cur_x   <= x0;
            cur_y   <= y0;
            start_x <= x0;
            start_y <= y0;
            end_x   <= x1;
            end_y   <= y1;
            dir_x   <= step_dir(x0, x1);
            dir_y   <= step_dir(y0, y1);
            fill_r  <= fill;
            color   <= pen_color;
        end else if (state == r_scan && !draw_busy) begin
            pix_cmd <= make_draw_cmd(fn_pxwri, color, cur_y, cur_x);
            cur_x   <= solid_row ? cur_x + dir_x : end_x;    // outline skips to far edge
        end else if (state == r_next_row && !draw_busy) begin
            cur_x <= start_x;
            cur_y <= cur_y + dir_y;
        end
    end

endmodule

/* src/draw_cmd_merge.sv */
`timescale 1ns/1ns

module draw_cmd_merge import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cfg_req,
    input  draw_cmd_t cfg_cmd,
    input  logic      line_req,
    input  logic      rect_req,
    input  draw_cmd_t line_cmd,
    input  draw_cmd_t rect_cmd,
    input  coord_t    max_x,
    input  coord_t    max_y,
    output logic      draw_cmd_rdy,
    output draw_cmd_t draw_cmd
);

    logic      pix_req;
    draw_cmd_t pix_cmd;
    coord_t    pix_x;
    coord_t    pix_y;
    logic      pix_in;                               // pixel inside the screen limit

    // only one engine runs at a time
    assign pix_req = line_req || rect_req;
    assign pix_cmd = line_req ? line_cmd : rect_cmd;
    assign pix_x   = pix_cmd[coord_w-1:0];
    assign pix_y   = pix_cmd[2*coord_w-1:coord_w];

    // sign bit set means a negative coordinate
    assign pix_in  = !pix_x[coord_w-1] && !pix_y[coord_w-1] &&
                     (pix_x <= max_x) && (pix_y <= max_y);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            draw_cmd_rdy <= 1'b0;
        else
            draw_cmd_rdy <= cfg_req || (pix_req && pix_in);
    end

    always_ff @(posedge clk) begin
        if (cfg_req)
            draw_cmd <= cfg_cmd;                     // config words never clipped
        else if (pix_req && pix_in)
            draw_cmd <= pix_cmd;
    end

endmodule

/* src/geometry_xy_plotter.sv */
`timescale 1ns/1ns

module geometry_xy_plotter import plotter_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fifo_cmd_ready,                // host write strobe
    input  cmd_word_t fifo_cmd_in,
    input  logic      draw_busy,                     // pixel writer stall
    output logic      load_cmd,
    output logic      draw_cmd_rdy,
    output draw_cmd_t draw_cmd,
    output logic      fifo_cmd_busy
);

    cmd_word_t head_word;
    logic      head_valid;
    logic      pop;
    logic      cfg_req;
    draw_cmd_t cfg_cmd;
    coord_t    max_x;
    coord_t    max_y;
    logic      line_start;
    logic      rect_start;
    coord_t    x0;
    coord_t    y0;
    coord_t    x1;
    coord_t    y1;
    logic      fill;
    color_t    pen_color;
    logic      line_running;
    logic      rect_running;
    logic      line_req;
    logic      rect_req;
    draw_cmd_t line_cmd;
    draw_cmd_t rect_cmd;
    logic      engine_running;

    assign engine_running = line_running || rect_running;
    assign load_cmd       = !engine_running;

    cmd_fifo u_cmd_fifo (
        .clk, .reset,
        .wr(fifo_cmd_ready), .wr_data(fifo_cmd_in), .pop,
        .head_word, .head_valid, .almost_full(fifo_cmd_busy)
    );

    cmd_decoder u_cmd_decoder (
        .clk, .reset, .head_word, .head_valid, .draw_busy, .engine_running,
        .pop, .cfg_req, .cfg_cmd, .max_x, .max_y, .line_start, .rect_start,
        .x0, .y0, .x1, .y1, .fill, .pen_color
    );

    line_engine u_line_engine (
        .clk, .reset, .start(line_start), .draw_busy, .x0, .y0, .x1, .y1, .pen_color,
        .running(line_running), .pix_req(line_req), .pix_cmd(line_cmd)
    );

    rect_engine u_rect_engine (
        .clk, .reset, .start(rect_start), .draw_busy, .x0, .y0, .x1, .y1, .fill, .pen_color,
        .running(rect_running), .pix_req(rect_req), .pix_cmd(rect_cmd)
    );

    draw_cmd_merge u_draw_cmd_merge (
        .clk, .reset, .cfg_req, .cfg_cmd, .line_req, .rect_req, .line_cmd, .rect_cmd,
        .max_x, .max_y, .draw_cmd_rdy, .draw_cmd
    );

endmodule

/* test/tb_plot_model.svh */
`ifndef TB_PLOT_MODEL_SVH
`define TB_PLOT_MODEL_SVH

// ********************************************************************
// reference model of the plotter, one command word at a time
// ********************************************************************
int          ref_x [4];                              // coordinate pairs as the decoder holds them
int          ref_y [4];
int          ref_max_x;                              // screen limit
int          ref_max_y;
logic [35:0] exp_words [$];                          // expected output of all tests, in order
int          work_cost;                              // rough cycle count, sizes the timeout

function automatic logic [35:0] pack_cmd(int func, int color, int y, int x);
    return {4'(func), 8'(color), 12'(y), 12'(x)};    // func | color | y | x
endfunction

function automatic int step_toward(int from, int to);
    return (to < from) ? -1 : (to == from) ? 0 : 1;
endfunction

task automatic clear_plot_state();
    for (int i = 0; i < 4; i++) begin
        ref_x[i] = 0;
        ref_y[i] = 0;
    end
    ref_max_x = 0;
    ref_max_y = 0;
    exp_words.delete();
    work_cost = 0;
endtask

// pixel survives only inside 0..max on both axes
task automatic put_pixel(int x, int y, int color);
    work_cost++;
    if (x >= 0 && y >= 0 && x < 2048 && y < 2048 && x <= ref_max_x && y <= ref_max_y)
        exp_words.push_back(pack_cmd(1, color, y, x));
endtask

task automatic plot_line(int color);
    int x;
    int y;
    int sx;
    int sy;
    int dx;
    int dy;
    int err;
    int e2;
    x   = ref_x[0];
    y   = ref_y[0];
    sx  = step_toward(x, ref_x[1]);
    sy  = step_toward(y, ref_y[1]);
    dx  = (ref_x[1] > x) ? ref_x[1] - x : x - ref_x[1];
    dy  = (ref_y[1] > y) ? y - ref_y[1] : ref_y[1] - y; // negative y span
    err = dx + dy;
    work_cost += 4;                                  // start, setup and finish cycles
    for (int n = 0; n < 4096; n++) begin
        put_pixel(x, y, color);
        if (x == ref_x[1] && y == ref_y[1])
            break;
        e2 = 2 * err;
        if (e2 > dy) begin
            x += sx;
            if (e2 + dy < dx) begin                  // diagonal
                y   += sy;
                err += dx + dy;
            end else begin
                err += dy;
            end
        end else if (e2 < dx) begin
            y   += sy;
            err += dx;
        end
    end
endtask

task automatic plot_rect(logic fill, int color);
    int  x;
    int  y;
    int  sx;
    int  sy;
    logic solid;
    sx = step_toward(ref_x[0], ref_x[1]);
    sy = step_toward(ref_y[0], ref_y[1]);
    y  = ref_y[0];
    work_cost += 2;
    for (int r = 0; r < 4096; r++) begin
        solid = fill || y == ref_y[0] || y == ref_y[1];
        x     = ref_x[0];
        for (int c = 0; c < 4096; c++) begin
            put_pixel(x, y, color);
            if (x == ref_x[1])
                break;
            x = solid ? x + sx : ref_x[1];           // outline jumps to the far edge
        end
        work_cost++;                                 // row change cycle
        if (y == ref_y[1])
            break;
        y += sy;
    end
endtask

task automatic apply_command(logic [15:0] word);
    logic [7:0] op;
    logic [7:0] d8;
    int         p;
    op = word[15:8];
    d8 = word[7:0];
    p  = op[1:0];
    work_cost++;
    if (op[7:6] == 2'b10)
        ref_x[op[5:4]] = word[11:0];
    else if (op[7:6] == 2'b11)
        ref_y[op[5:4]] = word[11:0];
    else if (op >= 124 && op <= 127)                 // destination address
        exp_words.push_back(pack_cmd(14, d8, ref_y[p], ref_x[p]));
    else if (op >= 120 && op <= 123)                 // source address
        exp_words.push_back(pack_cmd(15, d8, ref_y[p], ref_x[p]));
    else if (op >= 112 && op <= 115) begin           // raster widths
        p = (op == 112) ? 3 : 2;
        exp_words.push_back(pack_cmd(op[0] ? 12 : 13, d8, ref_y[p], ref_x[p]));
    end else if (op == 90 || op == 91)               // y is byte then high nibble
        exp_words.push_back(pack_cmd(op == 91 ? 10 : 11, d8, d8 * 16 + d8 / 16,
                                     (d8 % 16) * 16 + d8 / 16));
    else if (op >= 92 && op <= 95) begin             // 95 takes pair 0, 92 pair 3
        ref_max_x = ref_x[95 - op];
        ref_max_y = ref_y[95 - op];
    end else if (op[7:5] == 3'b000 && op[2:0] == 3'd1)
        plot_line(d8);
    else if (op[7:5] == 3'b000 && op[2:0] == 3'd2)
        plot_rect(op[3], d8);
endtask

`endif

/* test/tb_geometry_xy_plotter.sv */
`timescale 1ns/1ns

module tb_geometry_xy_plotter import plotter_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      fifo_cmd_ready;
    cmd_word_t fifo_cmd_in;
    logic      draw_busy;
    logic      load_cmd;
    logic      draw_cmd_rdy;
    draw_cmd_t draw_cmd;
    logic      fifo_cmd_busy;

    string       test_name [8];
    int          busy_mode [8];                      // 0 quiet, 1 random stalls, 2 held on writes
    int          word_first [8];
    int          word_count [8];
    int          exp_first [8];
    int          exp_count [8];
    int          num_tests;
    cmd_word_t   stim_words [$];                     // command words of all tests
    draw_cmd_t   got_words [$];                      // what the monitor saw in the current test
    logic        stall_en;
    logic        busy_hold;
    int          seed;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    `include "tb_plot_model.svh"

    geometry_xy_plotter u_geometry_xy_plotter (
        .clk, .reset, .fifo_cmd_ready, .fifo_cmd_in, .draw_busy,
        .load_cmd, .draw_cmd_rdy, .draw_cmd, .fifo_cmd_busy
    );

    always #20 clk = ~clk;

    always @(negedge clk)
        draw_busy <= busy_hold || (stall_en && ($random(seed) % 4 == 0));

    always @(negedge clk)
        if (draw_cmd_rdy === 1'b1)
            got_words.push_back(draw_cmd);           // rdy is a one cycle pulse

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [35:0] expected,
                         input logic [35:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ********************************************************************
    // stimulus table
    // ********************************************************************
    task automatic new_test(input string name, input int mode);
        test_name[num_tests]  = name;
        busy_mode[num_tests]  = mode;
        word_first[num_tests] = stim_words.size();
        num_tests++;
    endtask

    task automatic add_pair(input int pair, input int x, input int y);
        stim_words.push_back({2'b10, 2'(pair), 12'(x)});
        stim_words.push_back({2'b11, 2'(pair), 12'(y)});
    endtask

    task automatic add_line(input int x0, input int y0, input int x1, input int y1,
                            input int color);
        add_pair(0, x0, y0);
        add_pair(1, x1, y1);
        stim_words.push_back({8'h01, 8'(color)});
    endtask

    task automatic add_rect(input int x0, input int y0, input int x1, input int y1,
                            input logic fill, input int color);
        add_pair(0, x0, y0);
        add_pair(1, x1, y1);
        stim_words.push_back({fill ? 8'h0a : 8'h02, 8'(color)});
    endtask

    task automatic add_limit(input int mx, input int my);
        add_pair(3, mx, my);
        stim_words.push_back(16'h5c00);              // 92 picks pair 3
    endtask

    task automatic build_table();
        new_test("config_cmds", 0);
        add_pair(0, 'h123, 'h045);
        add_pair(1, 'h2ab, 'h3cd);
        add_pair(2, 'h111, 'h222);
        add_pair(3, 'h333, 'h044);
        stim_words.push_back(16'h7d5a);              // dest address, pair 1
        stim_words.push_back(16'h7a3c);              // source address, pair 2
        stim_words.push_back(16'h7166);              // 113 dest width
        stim_words.push_back(16'h7077);              // 112 source width, pair 3
        stim_words.push_back(16'h7388);              // 115 dest width
        stim_words.push_back(16'h5ba6);              // mask reset, pixel write
        stim_words.push_back(16'h5a7e);              // mask reset, paste
        stim_words.push_back(16'h7400);              // 116..119 no-ops
        stim_words.push_back(16'h7501);
        stim_words.push_back(16'h7602);
        stim_words.push_back(16'h77ff);
        stim_words.push_back(16'h5f00);              // limit from pair 0
        stim_words.push_back(16'h0500);              // unknown shape
        new_test("line_octants", 0);
        add_limit(2047, 2047);
        add_line(100, 100, 107, 103, 'hc3);
        add_line(100, 100, 97, 108, 'h3c);
        add_line(50, 60, 44, 57, 'h5a);
        add_line(20, 30, 23, 22, 'ha5);
        add_line(5, 5, 5, 5, 'h01);                  // single point
        new_test("rect_filled", 0);
        add_rect(10, 20, 14, 23, 1'b1, 'h11);
        add_rect(30, 5, 27, 2, 1'b1, 'h12);          // drawn toward smaller x and y
        new_test("rect_outline", 0);
        add_rect(40, 40, 46, 44, 1'b0, 'h22);
        add_rect(60, 60, 60, 63, 1'b0, 'h23);        // one column wide
        new_test("clip", 0);
        add_limit(20, 15);
        add_line(10, 5, 30, 20, 'h33);
        add_rect(17, 12, 22, 17, 1'b1, 'h34);
        add_rect(16, 10, 24, 18, 1'b0, 'h35);
        new_test("stall_mixed", 1);
        add_limit(2047, 2047);
        add_line(70, 10, 61, 16, 'h44);
        stim_words.push_back(16'h7c99);
        add_rect(3, 4, 8, 7, 1'b1, 'h45);
        add_rect(9, 9, 5, 13, 1'b0, 'h46);
        stim_words.push_back(16'h5a0f);
        new_test("fifo_full", 2);
        for (int i = 0; i < 11; i++)
            stim_words.push_back({8'(116 + i % 4), 8'(i)});
        add_pair(0, 5, 6);
        stim_words.push_back(16'h7c99);
        stim_words.push_back(16'h5b3c);              // 15 words in all
    endtask

    // ********************************************************************
    // one table entry: write, drain, compare
    // ********************************************************************
    task automatic run_test(input int t);
        int quiet;
        got_words.delete();
        stall_en  = (busy_mode[t] == 1);
        busy_hold = (busy_mode[t] == 2);
        for (int i = word_first[t]; i < word_first[t] + word_count[t]; i++) begin
            @(negedge clk);
            while (busy_mode[t] != 2 && fifo_cmd_busy) begin
                fifo_cmd_ready = 1'b0;
                @(negedge clk);
            end
            fifo_cmd_ready = 1'b1;
            fifo_cmd_in    = stim_words[i];
        end
        @(negedge clk);
        fifo_cmd_ready = 1'b0;
        if (busy_mode[t] == 2) begin
            check({test_name[t], ".fifo_cmd_busy_high"}, 1, fifo_cmd_busy);
            busy_hold = 1'b0;
        end
        quiet = 0;
        while (quiet < 4) begin                      // fifo empty and no engine for a while
            @(negedge clk);
            if (!u_geometry_xy_plotter.head_valid && load_cmd)
                quiet++;
            else
                quiet = 0;
        end
        stall_en = 1'b0;
        check({test_name[t], ".fifo_cmd_busy_low"}, 0, fifo_cmd_busy);
        check({test_name[t], ".count"}, exp_count[t], got_words.size());
        for (int i = 0; i < exp_count[t] && i < got_words.size(); i++)
            check($sformatf("%s.word%0d", test_name[t], i), exp_words[exp_first[t] + i],
                  got_words[i]);
    endtask

    initial begin
        int last;
        clk            = 1'b0;
        reset          = 1'b1;
        fifo_cmd_ready = 1'b0;
        fifo_cmd_in    = '0;
        draw_busy      = 1'b0;
        stall_en       = 1'b0;
        busy_hold      = 1'b0;
        seed           = 32'h27fb_bffe;
        errors         = 0;
        checks         = 0;
        cycles         = 0;
        cycle_limit    = 0;
        num_tests      = 0;
        build_table();
        clear_plot_state();
        for (int t = 0; t < num_tests; t++) begin
            last          = (t + 1 < num_tests) ? word_first[t + 1] : stim_words.size();
            word_count[t] = last - word_first[t];
            exp_first[t]  = exp_words.size();
            for (int i = word_first[t]; i < last; i++)
                apply_command(stim_words[i]);
            exp_count[t]  = exp_words.size() - exp_first[t];
            work_cost    += 8;                       // drain window
        end
        cycle_limit = 4 * work_cost + 16;            // reset cycles on top
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("reset.load_cmd", 1, load_cmd);
        check("reset.draw_cmd_rdy", 0, draw_cmd_rdy);
        check("reset.fifo_cmd_busy", 0, fifo_cmd_busy);
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
+incdir+test
common/plotter_pkg.sv
src/cmd_fifo.sv
src/cmd_decoder.sv
geometry/line_engine.sv
geometry/rect_engine.sv
src/draw_cmd_merge.sv
src/geometry_xy_plotter.sv
test/tb_geometry_xy_plotter.sv
